//--- logic/mac_id_pkg.sv
/*
 * Shared widths, opcodes and types of the RV32 decode/execute stage.
 * Only RV32I ALU ops and the custom-0 MAC are encoded here.
 * NUM_CREDITS sets both the buffer depth and the source's credits after reset.
 */
`default_nettype none

package mac_id_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned XLEN        = 32;
  localparam int unsigned REG_ADDR_W  = 5;
  localparam int unsigned NUM_REGS    = 2 ** REG_ADDR_W;
  localparam int unsigned NUM_CREDITS = 2;

  // Buffer pointer and occupancy widths
  localparam int unsigned BUF_PTR_W = (NUM_CREDITS > 1) ? $clog2(NUM_CREDITS) : 1;
  localparam int unsigned BUF_CNT_W = $clog2(NUM_CREDITS + 1);

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Major opcodes, MAC lives on custom-0
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_MAC    = 7'b0001011;

  // funct7 values, SUB sets word bit 30
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

  // funct3 values shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Instruction word and its two views
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
  } insn_u;

  // Decoded control of the head instruction
  typedef struct packed {
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  is_mac;
    logic                  we;
    logic                  illegal;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
  } dec_ctrl_t;

  // One retired instruction
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } retire_t;

endpackage

`default_nettype wire

//--- logic/insn_buffer.sv
/*
 * Credit-managed instruction FIFO, NUM_CREDITS entries deep.
 * No ready signal: the source must hold a credit for every push.
 * One credit returns per pop.
 */
`timescale 1ns/100ps
`default_nettype none

module insn_buffer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              insn_valid_i,
  input  mac_id_pkg::insn_u insn_i,
  input  logic              pop_i,
  output logic              head_valid_o,
  output mac_id_pkg::insn_u head_insn_o,
  output logic              credit_o
);

  import mac_id_pkg::*;

  insn_u                mem_q [NUM_CREDITS];
  logic [BUF_PTR_W-1:0] wr_ptr_q;
  logic [BUF_PTR_W-1:0] rd_ptr_q;
  logic [BUF_CNT_W-1:0] count_q;
  logic                 pop;

  // Circular pointer advance, also for depths that are not a power of two
  function automatic logic [BUF_PTR_W-1:0] ptr_inc(input logic [BUF_PTR_W-1:0] ptr);
    if (ptr == BUF_PTR_W'(NUM_CREDITS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Pops only count while an entry is present
  assign pop = pop_i & head_valid_o;

  // Control state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (insn_valid_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Occupancy only moves on a lone push or a lone pop
      if (insn_valid_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !insn_valid_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (insn_valid_i) begin
      mem_q[wr_ptr_q] <= insn_i;
    end
  end

  // Oldest entry is the head
  assign head_valid_o = (count_q != '0);
  assign head_insn_o  = mem_q[rd_ptr_q];

  // Freed slot goes straight back to the source
  assign credit_o = pop;

endmodule

`default_nettype wire

//--- logic/insn_decoder.sv
/*
 * Decodes R-type ADD/SUB/XOR/OR/AND, I-type ADDI/XORI/ORI/ANDI and MAC.
 * Every other encoding is flagged illegal with its write enable cleared.
 * Purely combinational.
 */
`timescale 1ns/100ps
`default_nettype none

module insn_decoder (
  input  mac_id_pkg::insn_u     insn_i,
  output mac_id_pkg::dec_ctrl_t ctrl_o
);

  import mac_id_pkg::*;

  always_comb begin
    ctrl_o = '0;

    // Register fields sit at the same place in both views
    ctrl_o.rs1 = insn_i.r.rs1;
    ctrl_o.rd  = insn_i.r.rd;

    // Sign-extended I immediate
    ctrl_o.imm = {{(XLEN - 12){insn_i.i.imm12[11]}}, insn_i.i.imm12};

    unique case (insn_i.r.opcode)

      ////////////////////////////////////////////////////////////
      // Register-register ALU ops
      ////////////////////////////////////////////////////////////
      OPC_OP: begin
        ctrl_o.rs2 = insn_i.r.rs2;
        ctrl_o.we  = 1'b1;
        unique case (insn_i.r.funct3)
          F3_ADD_SUB: begin
            if (insn_i.r.funct7 == F7_BASE) begin
              ctrl_o.alu_op = ALU_ADD;
            end else if (insn_i.r.funct7 == FUNCT7_SUB) begin
              ctrl_o.alu_op = ALU_SUB;
            end else begin
              ctrl_o.illegal = 1'b1;
            end
          end
          F3_XOR: begin
            ctrl_o.alu_op  = ALU_XOR;
            ctrl_o.illegal = (insn_i.r.funct7 != F7_BASE);
          end
          F3_OR: begin
            ctrl_o.alu_op  = ALU_OR;
            ctrl_o.illegal = (insn_i.r.funct7 != F7_BASE);
          end
          F3_AND: begin
            ctrl_o.alu_op  = ALU_AND;
            ctrl_o.illegal = (insn_i.r.funct7 != F7_BASE);
          end
          // SLL, SLT, SLTU, SRL/SRA not supported
          default: ctrl_o.illegal = 1'b1;
        endcase
      end

      ////////////////////////////////////////////////////////////
      // Register-immediate ALU ops
      ////////////////////////////////////////////////////////////
      OPC_OP_IMM: begin
        ctrl_o.use_imm = 1'b1;
        ctrl_o.we      = 1'b1;
        unique case (insn_i.i.funct3)
          F3_ADD_SUB: ctrl_o.alu_op = ALU_ADD;
          F3_XOR:     ctrl_o.alu_op = ALU_XOR;
          F3_OR:      ctrl_o.alu_op = ALU_OR;
          F3_AND:     ctrl_o.alu_op = ALU_AND;
          // Shifts and compares not supported
          default:    ctrl_o.illegal = 1'b1;
        endcase
      end

      // MAC adds rs1 * rs2 onto rd
      OPC_MAC: begin
        ctrl_o.rs2     = insn_i.r.rs2;
        ctrl_o.is_mac  = 1'b1;
        ctrl_o.we      = 1'b1;
        ctrl_o.alu_op  = ALU_ADD;
        ctrl_o.illegal = (insn_i.r.funct3 != 3'b000);
      end

      default: ctrl_o.illegal = 1'b1;
    endcase

    // An illegal word writes nothing and retires in one cycle
    if (ctrl_o.illegal) begin
      ctrl_o.we     = 1'b0;
      ctrl_o.is_mac = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
/*
 * 32 x XLEN flip-flop register file, three asynchronous read ports.
 * x0 reads as zero and ignores writes.
 * A write lands at the clock edge and is visible to reads after it.
 */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [mac_id_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [mac_id_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic [mac_id_pkg::REG_ADDR_W-1:0] raddr_c_i,
  output logic [mac_id_pkg::XLEN-1:0]       rdata_a_o,
  output logic [mac_id_pkg::XLEN-1:0]       rdata_b_o,
  output logic [mac_id_pkg::XLEN-1:0]       rdata_c_o,
  input  logic                             we_i,
  input  logic [mac_id_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [mac_id_pkg::XLEN-1:0]       wdata_i
);

  import mac_id_pkg::*;

  // x1..x31 only, x0 has no storage
  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Read ports
  // a and b feed rs1/rs2, c feeds rd as the MAC accumulator
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];
  assign rdata_c_o = (raddr_c_i == '0) ? '0 : regs_q[raddr_c_i];

endmodule

`default_nettype wire

//--- logic/exec_unit.sv
/*
 * Operand select, ALU and MAC datapath.
 * Product is low 32 bits only, signedness does not matter there.
 * acc_sel_i switches the result to intermediate plus rd for MAC cycle two.
 */
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  mac_id_pkg::dec_ctrl_t       ctrl_i,
  input  logic [mac_id_pkg::XLEN-1:0] rs1_val_i,
  input  logic [mac_id_pkg::XLEN-1:0] rs2_val_i,
  input  logic [mac_id_pkg::XLEN-1:0] rd_val_i,
  input  logic                        imd_we_i,
  input  logic                        acc_sel_i,
  output logic [mac_id_pkg::XLEN-1:0] result_o
);

  import mac_id_pkg::*;

  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] mul_lo;
  logic [XLEN-1:0] imd_q;
  logic [XLEN-1:0] acc_sum;

  ////////////////////////////////////////////////////////////
  // Operands and ALU
  ////////////////////////////////////////////////////////////

  // Immediate replaces rs2 for OP-IMM
  assign operand_b = ctrl_i.use_imm ? ctrl_i.imm : rs2_val_i;

  always_comb begin
    unique case (ctrl_i.alu_op)
      ALU_ADD: alu_result = rs1_val_i + operand_b;
      ALU_SUB: alu_result = rs1_val_i - operand_b;
      ALU_XOR: alu_result = rs1_val_i ^ operand_b;
      ALU_OR:  alu_result = rs1_val_i | operand_b;
      ALU_AND: alu_result = rs1_val_i & operand_b;
      default: alu_result = rs1_val_i + operand_b;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Multiply-accumulate
  ////////////////////////////////////////////////////////////

  // Low half of rs1 * rs2
  assign mul_lo = rs1_val_i * rs2_val_i;

  // Intermediate register, holds the product into the second cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imd_q <= '0;
    end else if (imd_we_i) begin
      imd_q <= mul_lo;
    end
  end

  // rd is not yet written, so rd_val_i still holds the old accumulator
  assign acc_sum = imd_q + rd_val_i;

  assign result_o = acc_sel_i ? acc_sum : alu_result;

endmodule

`default_nettype wire

//--- logic/id_fsm.sv
/*
 * FIRST_CYCLE/MULTI_CYCLE control of the head instruction.
 * Non-MAC ops retire in their first head cycle, a MAC in its second.
 * Retirement is never stalled, so pop and retire are the same event.
 */
`timescale 1ns/100ps
`default_nettype none

module id_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        head_valid_i,
  input  mac_id_pkg::dec_ctrl_t       ctrl_i,
  input  logic [mac_id_pkg::XLEN-1:0] result_i,
  output logic                        pop_o,
  output logic                        imd_we_o,
  output logic                        acc_sel_o,
  output logic                        rf_we_o,
  output mac_id_pkg::retire_t         retire_o
);

  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } id_state_e;

  id_state_e state_q;
  id_state_e state_d;
  logic      retire;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FIRST_CYCLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state and per-cycle strobes
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    retire    = 1'b0;
    imd_we_o  = 1'b0;
    acc_sel_o = 1'b0;

    unique case (state_q)
      FIRST_CYCLE: begin
        if (head_valid_i) begin
          if (ctrl_i.is_mac) begin
            // Capture product, hold the head one more cycle
            imd_we_o = 1'b1;
            state_d  = MULTI_CYCLE;
          end else begin
            retire = 1'b1;
          end
        end
      end
      MULTI_CYCLE: begin
        // Accumulate and retire the MAC
        acc_sel_o = 1'b1;
        retire    = 1'b1;
        state_d   = FIRST_CYCLE;
      end
      default: state_d = FIRST_CYCLE;
    endcase
  end

  assign pop_o = retire;

  // we is already clear for illegal words
  assign rf_we_o = retire & ctrl_i.we & (ctrl_i.rd != '0);

  // Retire record
  // Zero while idle so an empty buffer never leaks stale fields
  always_comb begin
    retire_o = '0;
    if (retire) begin
      retire_o.valid   = 1'b1;
      retire_o.illegal = ctrl_i.illegal;
      retire_o.rd      = ctrl_i.rd;
      retire_o.data    = ctrl_i.illegal ? '0 : result_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/mac_id_top.sv
/*
 * Decode/execute stage top, credit-based instruction input.
 * credit_o pulses once per retired instruction.
 * retire_o is valid for one cycle per instruction, in program order.
 */
`timescale 1ns/100ps
`default_nettype none

module mac_id_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                insn_valid_i,
  input  mac_id_pkg::insn_u   insn_i,
  output logic                credit_o,
  output mac_id_pkg::retire_t retire_o
);

  import mac_id_pkg::*;

  // Buffer head
  logic            head_valid;
  insn_u           head_insn;
  logic            pop;

  // Decode and datapath
  dec_ctrl_t       dec_ctrl;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] rd_val;
  logic [XLEN-1:0] result;

  // FSM strobes
  logic            imd_we;
  logic            acc_sel;
  logic            rf_we;

  insn_buffer insn_buffer_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_valid_i (insn_valid_i),
    .insn_i       (insn_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_insn_o  (head_insn),
    .credit_o     (credit_o)
  );

  insn_decoder insn_decoder_i (
    .insn_i (head_insn),
    .ctrl_o (dec_ctrl)
  );

  // Port c reads rd for the accumulate
  reg_file reg_file_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec_ctrl.rs1),
    .raddr_b_i (dec_ctrl.rs2),
    .raddr_c_i (dec_ctrl.rd),
    .rdata_a_o (rs1_val),
    .rdata_b_o (rs2_val),
    .rdata_c_o (rd_val),
    .we_i      (rf_we),
    .waddr_i   (dec_ctrl.rd),
    .wdata_i   (result)
  );

  exec_unit exec_unit_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .ctrl_i    (dec_ctrl),
    .rs1_val_i (rs1_val),
    .rs2_val_i (rs2_val),
    .rd_val_i  (rd_val),
    .imd_we_i  (imd_we),
    .acc_sel_i (acc_sel),
    .result_o  (result)
  );

  id_fsm id_fsm_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_valid_i (head_valid),
    .ctrl_i       (dec_ctrl),
    .result_i     (result),
    .pop_o        (pop),
    .imd_we_o     (imd_we),
    .acc_sel_o    (acc_sel),
    .rf_we_o      (rf_we),
    .retire_o     (retire_o)
  );

endmodule

`default_nettype wire

//--- bench/mac_id_assertions.sv
/*
 * Protocol checks on the mac_id_top ports, bound into the top level.
 * Both ports are sampled at the rising clock edge outside reset.
 */
`timescale 1ns/100ps
`default_nettype none

module mac_id_assertions (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                credit_o,
  input mac_id_pkg::retire_t retire_o
);

  ////////////////////////////////////////////////////////////
  // Credit return
  ////////////////////////////////////////////////////////////

  // One credit per retired instruction in the same cycle
  credit_per_retire: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    credit_o == retire_o.valid
  ) else $error("credit_o does not follow retire_o.valid");

  ////////////////////////////////////////////////////////////
  // Retire port
  ////////////////////////////////////////////////////////////

  // Buffer is empty right after reset, so nothing can retire
  quiet_after_reset: assert property (
    @(posedge clk_i)
    $rose(rst_ni) |-> !retire_o.valid
  ) else $error("retirement in the first cycle after reset release");

  // No unknown bits on the retire record once out of reset
  retire_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(retire_o)
  ) else $error("retire_o carries unknown bits");

endmodule

`default_nettype wire

//--- bench/tb_mac_id.sv
/*
 * Testbench for mac_id_top: credit-respecting directed and random stimulus.
 * Expected retirements come from a register model updated in issue order.
 * Retire records are checked by a concurrent assertion on retire_o.valid.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_mac_id;

  import mac_id_pkg::*;

  localparam int WAIT_LIMIT  = 50;
  localparam int DRAIN_LIMIT = 200;
  localparam int NUM_RANDOM  = 150;

  logic    clk_i;
  logic    rst_ni;
  logic    insn_valid_i;
  insn_u   insn_i;
  logic    credit_o;
  retire_t retire_o;

  // Reference state
  logic [XLEN-1:0] model_regs [32];
  retire_t         exp_q [$];
  string           name_q [$];
  retire_t         exp_cur;
  string           exp_name;
  logic            exp_known;
  logic            timed_out;
  int              credits;
  int              issued;
  int              retired;
  int              mismatch_errors;
  int              other_errors;

  mac_id_top mac_id_top_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_valid_i (insn_valid_i),
    .insn_i       (insn_i),
    .credit_o     (credit_o),
    .retire_o     (retire_o)
  );

  bind mac_id_top mac_id_assertions mac_id_assertions_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .credit_o (credit_o),
    .retire_o (retire_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  // Mid-cycle sample of the port latches the expected record for the next edge
  always @(negedge clk_i) begin
    if (rst_ni && retire_o.valid) begin
      retired++;
      exp_known = (exp_q.size() > 0);
      if (exp_known) begin
        exp_cur  = exp_q.pop_front();
        exp_name = name_q.pop_front();
      end
    end
  end

  // Credits return at the edge that closes the retiring cycle
  always @(posedge clk_i) begin
    if (rst_ni && credit_o) begin
      credits++;
    end
  end

  retire_check: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    retire_o.valid |-> (exp_known && (retire_o == exp_cur))
  ) else begin
    if (!exp_known) begin
      other_errors++;
      $display("retirement seen with no instruction outstanding");
    end else begin
      mismatch_errors++;
      $display(
        "MISMATCH %s: expected illegal=%0b rd=%0d data=%h, actual illegal=%0b rd=%0d data=%h",
        exp_name, exp_cur.illegal, exp_cur.rd, exp_cur.data,
        $sampled(retire_o.illegal), $sampled(retire_o.rd), $sampled(retire_o.data));
    end
  end

  // Source never runs ahead of its credits
  credit_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (issued - retired) <= int'(NUM_CREDITS)
  ) else begin
    other_errors++;
    $display("more instructions outstanding than credits allow");
  end

  ////////////////////////////////////////////////////////////
  // Encoders and reference model
  ////////////////////////////////////////////////////////////

  function automatic insn_u encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2, input logic [6:0] opc);
    insn_u w;
    w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
    return w;
  endfunction

  function automatic insn_u encode_i(input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [11:0] imm);
    insn_u w;
    w.i = '{imm12: imm, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP_IMM};
    return w;
  endfunction

  // Computes the retire record from the raw word and updates the model
  function automatic void predict(input insn_u word, input string name);
    logic [31:0] w;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic        legal;
    retire_t     exp;
    w     = word;
    f7    = w[31:25];
    f3    = w[14:12];
    rd    = w[11:7];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm   = {{20{w[31]}}, w[31:20]};
    res   = '0;
    legal = 1'b1;
    case (w[6:0])
      OPC_OP: begin
        case ({f7, f3})
          {7'h00, 3'b000}: res = a + b;
          {7'h20, 3'b000}: res = a - b;
          {7'h00, 3'b100}: res = a ^ b;
          {7'h00, 3'b110}: res = a | b;
          {7'h00, 3'b111}: res = a & b;
          default:         legal = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        case (f3)
          3'b000:  res = a + imm;
          3'b100:  res = a ^ imm;
          3'b110:  res = a | imm;
          3'b111:  res = a & imm;
          default: legal = 1'b0;
        endcase
      end
      // Accumulate the low 32 bits of the product onto the old rd
      OPC_MAC: begin
        legal = (f3 == 3'b000);
        res   = model_regs[rd] + a * b;
      end
      default: legal = 1'b0;
    endcase
    if (legal && (rd != 5'd0)) begin
      model_regs[rd] = res;
    end
    exp.valid   = 1'b1;
    exp.illegal = !legal;
    exp.rd      = rd;
    exp.data    = legal ? res : '0;
    exp_q.push_back(exp);
    name_q.push_back(name);
    issued++;
  endfunction

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  task automatic finish_run();
    $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
    if ((mismatch_errors + other_errors) == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  // Later stimulus is skipped once a wait has expired
  task automatic give_up(input string what);
    other_errors++;
    timed_out = 1'b1;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      insn_valid_i = 1'b0;
    end
  endtask

  // One instruction on the next falling edge that has a credit
  task automatic issue(input insn_u word, input string name);
    int waited;
    waited = 0;
    @(negedge clk_i);
    insn_valid_i = 1'b0;
    while ((credits == 0) && !timed_out) begin
      if (waited >= WAIT_LIMIT) begin
        give_up("an instruction credit");
      end else begin
        waited++;
        @(negedge clk_i);
      end
    end
    if (!timed_out) begin
      insn_valid_i = 1'b1;
      insn_i       = word;
      credits--;
      predict(word, name);
    end
  endtask

  task automatic issue_random();
    int         kind;
    int         sel;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    insn_u      word;
    kind = int'($urandom % 10);
    sel  = int'($urandom % 5);
    rd   = 5'($urandom);
    rs1  = 5'($urandom);
    rs2  = 5'($urandom);
    if (kind < 4) begin
      case (sel)
        0:       word = encode_r(7'h00, 3'b000, rd, rs1, rs2, OPC_OP);
        1:       word = encode_r(7'h20, 3'b000, rd, rs1, rs2, OPC_OP);
        2:       word = encode_r(7'h00, 3'b100, rd, rs1, rs2, OPC_OP);
        3:       word = encode_r(7'h00, 3'b110, rd, rs1, rs2, OPC_OP);
        default: word = encode_r(7'h00, 3'b111, rd, rs1, rs2, OPC_OP);
      endcase
    end else if (kind < 7) begin
      case (sel)
        0:       word = encode_i(3'b000, rd, rs1, 12'($urandom));
        1:       word = encode_i(3'b100, rd, rs1, 12'($urandom));
        2:       word = encode_i(3'b110, rd, rs1, 12'($urandom));
        default: word = encode_i(3'b111, rd, rs1, 12'($urandom));
      endcase
    end else if (kind < 9) begin
      word = encode_r(7'h00, 3'b000, rd, rs1, rs2, OPC_MAC);
    end else begin
      // SLL is outside the supported set
      word = encode_r(7'h00, 3'b001, rd, rs1, rs2, OPC_OP);
    end
    issue(word, "random");
    idle(int'($urandom % 3));
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk_i);
    insn_valid_i = 1'b0;
    while ((retired != issued) && !timed_out) begin
      if (waited >= DRAIN_LIMIT) begin
        give_up("outstanding retirements");
      end else begin
        waited++;
        @(negedge clk_i);
      end
    end
    // Let the last retirement reach its check edge
    idle(2);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h15cb));
    rst_ni          = 1'b0;
    insn_valid_i    = 1'b0;
    insn_i          = '0;
    exp_cur         = '0;
    exp_name        = "";
    exp_known       = 1'b0;
    timed_out       = 1'b0;
    credits         = int'(NUM_CREDITS);
    issued          = 0;
    retired         = 0;
    mismatch_errors = 0;
    other_errors    = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    // ALU ops, negative immediate and SUB wraparound
    issue(encode_i(3'b000, 5'd1, 5'd0, 12'd100), "alu");
    issue(encode_i(3'b000, 5'd2, 5'd0, 12'(-7)), "alu");
    issue(encode_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2, OPC_OP), "alu");
    issue(encode_r(7'h20, 3'b000, 5'd4, 5'd2, 5'd1, OPC_OP), "alu");
    issue(encode_r(7'h20, 3'b000, 5'd5, 5'd0, 5'd1, OPC_OP), "alu");
    issue(encode_r(7'h00, 3'b100, 5'd6, 5'd1, 5'd2, OPC_OP), "alu");
    issue(encode_r(7'h00, 3'b110, 5'd7, 5'd1, 5'd2, OPC_OP), "alu");
    issue(encode_r(7'h00, 3'b111, 5'd8, 5'd1, 5'd2, OPC_OP), "alu");
    issue(encode_i(3'b100, 5'd9, 5'd1, 12'hfff), "alu");
    issue(encode_i(3'b110, 5'd10, 5'd2, 12'h0f0), "alu");
    issue(encode_i(3'b111, 5'd11, 5'd9, 12'h7ff), "alu");

    // MAC results are read back by an ADD with x0 and one MAC has rd equal to rs1
    issue(encode_i(3'b000, 5'd12, 5'd0, 12'd5), "mac");
    issue(encode_i(3'b000, 5'd13, 5'd0, 12'(-3)), "mac");
    issue(encode_i(3'b000, 5'd14, 5'd0, 12'd1000), "mac");
    issue(encode_r(7'h00, 3'b000, 5'd14, 5'd12, 5'd13, OPC_MAC), "mac");
    issue(encode_r(7'h00, 3'b000, 5'd15, 5'd14, 5'd0, OPC_OP), "mac");
    issue(encode_r(7'h00, 3'b000, 5'd12, 5'd12, 5'd13, OPC_MAC), "mac");
    issue(encode_r(7'h00, 3'b000, 5'd16, 5'd12, 5'd0, OPC_OP), "mac");
    issue(encode_r(7'h00, 3'b000, 5'd9, 5'd9, 5'd11, OPC_MAC), "mac");

    // Back-to-back dependent chain
    issue(encode_i(3'b000, 5'd20, 5'd0, 12'd3), "chain");
    issue(encode_r(7'h00, 3'b000, 5'd20, 5'd20, 5'd20, OPC_OP), "chain");
    issue(encode_r(7'h00, 3'b000, 5'd20, 5'd20, 5'd20, OPC_MAC), "chain");
    issue(encode_r(7'h00, 3'b000, 5'd21, 5'd20, 5'd0, OPC_OP), "chain");
    issue(encode_r(7'h20, 3'b000, 5'd21, 5'd21, 5'd20, OPC_OP), "chain");

    // Illegal words leave x1 untouched
    issue(32'hffff_ffff, "illegal");
    issue(encode_r(7'h01, 3'b000, 5'd1, 5'd2, 5'd3, OPC_OP), "illegal");
    issue(encode_r(7'h00, 3'b001, 5'd1, 5'd2, 5'd3, OPC_OP), "illegal");
    issue(encode_r(7'h00, 3'b011, 5'd1, 5'd2, 5'd3, OPC_MAC), "illegal");
    issue(encode_i(3'b001, 5'd1, 5'd2, 12'd1), "illegal");
    issue(encode_r(7'h00, 3'b000, 5'd23, 5'd1, 5'd0, OPC_OP), "illegal");

    // Writes to x0 are dropped
    issue(encode_i(3'b000, 5'd0, 5'd1, 12'd5), "x0");
    issue(encode_r(7'h00, 3'b000, 5'd0, 5'd12, 5'd13, OPC_MAC), "x0");
    issue(encode_r(7'h00, 3'b000, 5'd22, 5'd0, 5'd1, OPC_OP), "x0");

    idle(3);
    repeat (NUM_RANDOM) issue_random();

    drain();
    final_count: assert (retired == issued && credits == int'(NUM_CREDITS)) else begin
      other_errors++;
      $display("retired %0d of %0d issued, %0d credits left", retired, issued, credits);
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/mac_id_pkg.sv
logic/insn_buffer.sv
logic/insn_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/id_fsm.sv
logic/mac_id_top.sv
bench/mac_id_assertions.sv
bench/tb_mac_id.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is zero only if the pass message was printed.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mac_id -Mdir obj_dir -f vlog.f

output="$(./obj_dir/Vtb_mac_id 2>&1)" || true
echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi
